/* include/fpu_settings.svh */
// fpu unit latency, tag width, float field sizes and constant bit patterns
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// cycles from request to result, also the two register ranks of fmul
`define FPU_LATENCY 2

// request tag carried through to the response
`define FPU_TAG_W 4

// single precision field widths
`define FPU_EXP_W 8
`define FPU_MAN_W 23
`define FPU_OP_W 4

// 1.0 as returned by a true compare
`define FPU_ONE 32'h3F80_0000

`endif

/* src/fpu_pkg.sv */
// fpu_pkg: float, opcode, request, metadata and response types
`include "fpu_settings.svh"
`default_nettype none

package fpu_pkg;

    // sign, biased exponent, mantissa without the hidden one
    typedef struct packed {
        logic                  sign;
        logic [`FPU_EXP_W-1:0] exp;
        logic [`FPU_MAN_W-1:0] man;
    } float_t;

    typedef enum logic [`FPU_OP_W-1:0] {
        op_fmul   = 4'h0,
        op_fsgnj  = 4'h1,
        op_fsgnjn = 4'h2,
        op_fsgnjx = 4'h3,
        op_fmin   = 4'h4,
        op_fmax   = 4'h5,
        op_feq    = 4'h6,
        op_flt    = 4'h7,
        op_fle    = 4'h8
    } fpu_op_e;

    // one request per cycle while in_valid is high
    typedef struct packed {
        fpu_op_e               op;
        logic [`FPU_TAG_W-1:0] tag;
        float_t                x1;
        float_t                x2;
    } fpu_req_t;

    // travels beside the multiplier to pick the result at the end
    typedef struct packed {
        fpu_op_e               op;
        logic [`FPU_TAG_W-1:0] tag;
    } fpu_meta_t;

    typedef struct packed {
        logic [`FPU_TAG_W-1:0] tag;
        float_t                y;
        logic                  ovf;
    } fpu_resp_t;

endpackage

`default_nettype wire

/* src/delay_pipe.sv */
// delay_pipe: fixed-depth register pipeline for any payload type plus valid
`timescale 1ns/1ps
`default_nettype none

module delay_pipe #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic rstn,
    input  logic in_valid,
    input  T     din,
    output logic out_valid,
    output T     dout
);

    T                 data_q [DEPTH];
    logic [DEPTH-1:0] valid_q;

    // only the valid bits need a known state after reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= din;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign dout      = data_q[DEPTH-1];

endmodule

`default_nettype wire

/* src/fmul.sv */
// fmul: truncating single-precision multiplier with saturation and overflow flag
`timescale 1ns/1ps
`default_nettype none

module fmul (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] x1,
    input  logic [31:0] x2,
    output logic [31:0] y,
    output logic        ovf
);
    import fpu_pkg::*;

    // rank 1, partial products with raw signs and exponents
    typedef struct packed {
        logic [25:0] hh;
        logic [23:0] hl;
        logic [23:0] lh;
        logic        s1;
        logic        s2;
        logic [7:0]  e1;
        logic [7:0]  e2;
    } st1_t;

    // rank 2, normalised mantissa and exponent before the shift
    typedef struct packed {
        logic        sign;
        logic [22:0] man;
        logic [9:0]  exp0;
        logic [1:0]  shift;
        logic        zero;
    } st2_t;

    float_t      a;
    float_t      b;
    logic [12:0] hi1;
    logic [12:0] hi2;
    logic [10:0] lo1;
    logic [10:0] lo2;
    st1_t        st1_d;
    st1_t        st1_q;
    st2_t        st2_d;
    st2_t        st2_q;
    logic [26:0] mmul;
    logic [9:0]  exp_sum;
    logic        over;
    logic        under;
    float_t      res;

    // stage 0: split 24-bit mantissas into 13 high and 11 low bits
    assign a   = x1;
    assign b   = x2;
    assign hi1 = {1'b1, a.man[22:11]};
    assign lo1 = a.man[10:0];
    assign hi2 = {1'b1, b.man[22:11]};
    assign lo2 = b.man[10:0];

    // low x low is dropped, the +2 below stands in for it
    always_comb begin
        st1_d.hh = hi1 * hi2;
        st1_d.hl = hi1 * lo2;
        st1_d.lh = lo1 * hi2;
        st1_d.s1 = a.sign;
        st1_d.s2 = b.sign;
        st1_d.e1 = a.exp;
        st1_d.e2 = b.exp;
    end

    // stage 1: 1.0 sits at bit 24 of the sum
    assign mmul = {1'b0, st1_q.hh}
                + {14'd0, st1_q.hl[23:11]}
                + {14'd0, st1_q.lh[23:11]}
                + 27'd2;

    always_comb begin
        st2_d.sign = st1_q.s1 ^ st1_q.s2;
        // offset by 256 so bits 9 and 8 show over and underflow
        st2_d.exp0 = {2'b00, st1_q.e1} + {2'b00, st1_q.e2} + 10'd129;
        st2_d.zero = (st1_q.e1 == 8'd0) || (st1_q.e2 == 8'd0);
        if (mmul[26]) begin
            st2_d.shift = 2'd2;
            st2_d.man   = mmul[25:3];
        end else if (mmul[25]) begin
            st2_d.shift = 2'd1;
            st2_d.man   = mmul[24:2];
        end else begin
            st2_d.shift = 2'd0;
            st2_d.man   = mmul[23:1];
        end
    end

    // stage 2: biased exponent is exp_sum - 256
    assign exp_sum = st2_q.exp0 + {8'd0, st2_q.shift};
    assign over    = exp_sum >= 10'd511;
    assign under   = exp_sum <= 10'd256;

    always_comb begin
        res.sign = st2_q.sign;
        if (st2_q.zero || under) begin
            res.exp = 8'd0;
            res.man = '0;
        end else if (over) begin
            res.exp = 8'hff;
            res.man = '0;
        end else begin
            res.exp = exp_sum[7:0];
            res.man = st2_q.man;
        end
    end

    assign y   = res;
    assign ovf = over && !st2_q.zero;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            st1_q <= '0;
            st2_q <= '0;
        end else begin
            st1_q <= st1_d;
            st2_q <= st2_d;
        end
    end

endmodule

`default_nettype wire

/* src/fpu_simple.sv */
// fpu_simple: sign injection, min/max and compares on sign-magnitude floats
`timescale 1ns/1ps
`include "fpu_settings.svh"
`default_nettype none

module fpu_simple (
    input  fpu_pkg::fpu_op_e op,
    input  fpu_pkg::float_t  x1,
    input  fpu_pkg::float_t  x2,
    output fpu_pkg::float_t  y
);
    import fpu_pkg::*;

    logic lt_12;
    logic lt_21;
    logic eq_12;

    // exponent 0 counts as zero whatever the mantissa
    function automatic logic [30:0] magnitude(float_t a);
        return (a.exp == '0) ? 31'd0 : {a.exp, a.man};
    endfunction

    // zeros are always positive, so +0 and -0 match
    function automatic logic eff_sign(float_t a);
        return (a.exp != '0) && a.sign;
    endfunction

    function automatic logic is_equal(float_t a, float_t b);
        return (eff_sign(a) == eff_sign(b)) && (magnitude(a) == magnitude(b));
    endfunction

    function automatic logic is_less(float_t a, float_t b);
        logic        sa;
        logic        sb;
        logic [30:0] ma;
        logic [30:0] mb;
        sa = eff_sign(a);
        sb = eff_sign(b);
        ma = magnitude(a);
        mb = magnitude(b);
        if (sa != sb) begin
            return sa;
        end
        // larger magnitude is smaller among negatives
        if (sa) begin
            return ma > mb;
        end
        return ma < mb;
    endfunction

    assign lt_12 = is_less(x1, x2);
    assign lt_21 = is_less(x2, x1);
    assign eq_12 = is_equal(x1, x2);

    always_comb begin
        case (op)
            op_fsgnj: begin
                y = {x2.sign, x1.exp, x1.man};
            end
            op_fsgnjn: begin
                y = {~x2.sign, x1.exp, x1.man};
            end
            op_fsgnjx: begin
                y = {x1.sign ^ x2.sign, x1.exp, x1.man};
            end
            // ties keep x1
            op_fmin: begin
                y = lt_21 ? x2 : x1;
            end
            op_fmax: begin
                y = lt_12 ? x2 : x1;
            end
            op_feq: begin
                y = eq_12 ? `FPU_ONE : '0;
            end
            op_flt: begin
                y = lt_12 ? `FPU_ONE : '0;
            end
            op_fle: begin
                y = (lt_12 || eq_12) ? `FPU_ONE : '0;
            end
            // fmul result comes from the multiplier
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/fpu_top.sv */
// fpu_top: request decode, fmul and fpu_simple, latency alignment, result select
`timescale 1ns/1ps
`include "fpu_settings.svh"
`default_nettype none

module fpu_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  fpu_pkg::fpu_req_t  req,
    output logic               out_valid,
    output fpu_pkg::fpu_resp_t resp
);
    import fpu_pkg::*;

    logic [31:0] mul_y;
    logic        mul_ovf;
    float_t      simple_y;
    fpu_meta_t   meta_in;
    fpu_meta_t   meta_out;
    fpu_resp_t   res_in;
    fpu_resp_t   res_out;

    // multiplier runs every cycle, its output is only used for op_fmul
    fmul mul0 (
        .clk  (clk),
        .rstn (rstn),
        .x1   (32'(req.x1)),
        .x2   (32'(req.x2)),
        .y    (mul_y),
        .ovf  (mul_ovf)
    );

    fpu_simple simple0 (
        .op (req.op),
        .x1 (req.x1),
        .x2 (req.x2),
        .y  (simple_y)
    );

    assign meta_in = '{op: req.op, tag: req.tag};
    assign res_in  = '{tag: req.tag, y: simple_y, ovf: 1'b0};

    delay_pipe #(
        .T     (fpu_meta_t),
        .DEPTH (`FPU_LATENCY)
    ) meta_pipe (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .din       (meta_in),
        .out_valid (out_valid),
        .dout      (meta_out)
    );

    // same valid as meta_pipe, so its own valid is left open
    delay_pipe #(
        .T     (fpu_resp_t),
        .DEPTH (`FPU_LATENCY)
    ) res_pipe (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .din       (res_in),
        .out_valid (),
        .dout      (res_out)
    );

    always_comb begin
        resp.tag = meta_out.tag;
        if (meta_out.op == op_fmul) begin
            resp.y   = float_t'(mul_y);
            resp.ovf = mul_ovf;
        end else begin
            resp.y   = res_out.y;
            resp.ovf = res_out.ovf;
        end
    end

endmodule

`default_nettype wire

/* testbench/fpu_chk.sv */
// fpu_chk: bound assertions on result latency, valid state and overflow encoding
`timescale 1ns/1ps
`include "fpu_settings.svh"
`default_nettype none

module fpu_chk (
    input logic               clk,
    input logic               rstn,
    input logic               in_valid,
    input logic               out_valid,
    input fpu_pkg::fpu_resp_t resp
);

    // every request comes out after the fixed latency, idle cycles too
    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        out_valid == $past(in_valid, `FPU_LATENCY))
        else $error("out_valid differs from in_valid %0d cycles earlier", `FPU_LATENCY);

    a_valid_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(out_valid))
        else $error("out_valid is unknown");

    // saturated product is infinity
    a_ovf_inf: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && resp.ovf) |-> (resp.y.exp == 8'hff))
        else $error("ovf set with exponent %h", resp.y.exp);

endmodule

bind fpu_top fpu_chk chk0 (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .resp      (resp)
);

`default_nettype wire

/* testbench/tb_fpu.sv */
// tb_fpu: clock, reset, xorshift stimulus, reference model, scoreboard, tests, watchdog
`timescale 1ns/1ps
`include "fpu_settings.svh"
`default_nettype none

module tb_fpu;
    import fpu_pkg::*;

    localparam int N_OPS = 32;
    // five tests of N_OPS back to back, the gap test takes up to 3 cycles per op
    localparam int TOTAL_OPS = 8 * N_OPS;

    logic      clk;
    logic      rstn;
    logic      in_valid;
    fpu_req_t  req;
    logic      out_valid;
    fpu_resp_t resp;

    logic [31:0]           rng_state;
    logic [`FPU_TAG_W-1:0] next_tag;
    int                    cyc;
    int                    n_checks;
    int                    n_errors;
    int                    checks_at_start;
    int                    errors_at_start;
    fpu_resp_t             exp_q[$];
    int                    cyc_q[$];

    fpu_top dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .resp      (resp)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // random sign and mantissa, exponent in lo .. lo+span-1
    function automatic float_t rand_float(int lo, int span);
        float_t      f;
        logic [31:0] r;
        r = next_rand();
        f.sign = r[31];
        f.man  = r[22:0];
        f.exp  = 8'(lo + int'(next_rand() % 32'(span)));
        return f;
    endfunction

    // product of the high parts plus the cross terms above bit 11, plus 2, truncated
    function automatic fpu_resp_t model_fmul(float_t a, float_t b);
        fpu_resp_t   r;
        logic [26:0] ha;
        logic [26:0] la;
        logic [26:0] hb;
        logic [26:0] lb;
        logic [26:0] sum;
        int          top;
        int          e;
        r  = '0;
        ha = 27'({1'b1, a.man[22:11]});
        la = 27'(a.man[10:0]);
        hb = 27'({1'b1, b.man[22:11]});
        lb = 27'(b.man[10:0]);
        sum = ha * hb + ((ha * lb) >> 11) + ((la * hb) >> 11) + 27'd2;
        top = 26;
        while (!sum[top]) begin
            top--;
        end
        // 1.0 lands on bit 24
        e = int'(a.exp) + int'(b.exp) - 127 + (top - 24);
        r.y.sign = a.sign ^ b.sign;
        r.y.man  = 23'(sum >> (top - 23));
        r.y.exp  = 8'(e);
        if (a.exp == 8'd0 || b.exp == 8'd0 || e <= 0) begin
            r.y.exp = 8'd0;
            r.y.man = '0;
        end else if (e >= 255) begin
            r.y.exp = 8'hff;
            r.y.man = '0;
            r.ovf   = 1'b1;
        end
        return r;
    endfunction

    // signed ordering key, any exponent 0 value is plain zero
    function automatic int order_key(float_t a);
        int mag;
        mag = int'({a.exp, a.man});
        if (a.exp == 8'd0) begin
            return 0;
        end
        return a.sign ? -mag : mag;
    endfunction

    function automatic fpu_resp_t model(fpu_op_e op, logic [`FPU_TAG_W-1:0] tag,
                                        float_t a, float_t b);
        fpu_resp_t r;
        int        k1;
        int        k2;
        k1 = order_key(a);
        k2 = order_key(b);
        r  = '0;
        case (op)
            op_fmul:   r = model_fmul(a, b);
            op_fsgnj:  r.y = '{sign: b.sign, exp: a.exp, man: a.man};
            op_fsgnjn: r.y = '{sign: !b.sign, exp: a.exp, man: a.man};
            op_fsgnjx: r.y = '{sign: a.sign ^ b.sign, exp: a.exp, man: a.man};
            op_fmin:   r.y = (k2 < k1) ? b : a;
            op_fmax:   r.y = (k1 < k2) ? b : a;
            op_feq:    r.y = (k1 == k2) ? float_t'(`FPU_ONE) : float_t'(32'd0);
            op_flt:    r.y = (k1 < k2) ? float_t'(`FPU_ONE) : float_t'(32'd0);
            op_fle:    r.y = (k1 <= k2) ? float_t'(`FPU_ONE) : float_t'(32'd0);
            default:   r.y = '0;
        endcase
        r.tag = tag;
        return r;
    endfunction

    task automatic check(string what, logic [63:0] got, logic [63:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic issue(fpu_op_e op, float_t a, float_t b);
        @(negedge clk);
        in_valid = 1'b1;
        req      = '{op: op, tag: next_tag, x1: a, x2: b};
        exp_q.push_back(model(op, next_tag, a, b));
        // edge at which the request is sampled
        cyc_q.push_back(cyc + 1);
        next_tag++;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic start_test();
        checks_at_start = n_checks;
        errors_at_start = n_errors;
    endtask

    task automatic end_test(string name);
        idle(1);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("test %s: %0d checks, %0d errors", name,
                 n_checks - checks_at_start, n_errors - errors_at_start);
    endtask

    // outputs come straight from registers, stable at the falling edge
    always @(negedge clk) begin : scoreboard
        fpu_resp_t exp_r;
        int        issued;
        if (rstn && out_valid) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("unexpected result at %0t ns with no request outstanding", $time);
            end else begin
                exp_r  = exp_q.pop_front();
                issued = cyc_q.pop_front();
                check("tag", 64'(resp.tag), 64'(exp_r.tag));
                check("y", 64'(resp.y), 64'(exp_r.y));
                check("ovf", 64'(resp.ovf), 64'(exp_r.ovf));
                // the consumer takes the result at the next rising edge
                check("latency", 64'(cyc + 1 - issued), 64'(`FPU_LATENCY));
            end
        end
    end

    initial begin : watchdog
        #((TOTAL_OPS + 50) * 20);
        $display("timeout: results did not arrive within the time limit");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        float_t a;
        float_t b;
        clk       = 1'b0;
        rstn      = 1'b0;
        in_valid  = 1'b0;
        req       = '0;
        rng_state = 32'd3349;
        next_tag  = '0;
        cyc       = 0;
        n_checks  = 0;
        n_errors  = 0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        start_test();
        for (int i = 0; i < N_OPS; i++) begin
            issue(op_fmul, rand_float(100, 55), rand_float(100, 55));
        end
        end_test("fmul_random");

        start_test();
        for (int i = 0; i < N_OPS; i++) begin
            a = rand_float(0, 1);
            b = rand_float(1, 254);
            if (next_rand() % 2 == 0) begin
                issue(op_fmul, a, b);
            end else begin
                issue(op_fmul, b, a);
            end
        end
        end_test("fmul_zero");

        start_test();
        for (int i = 0; i < N_OPS; i++) begin
            if (i % 2 == 0) begin
                issue(op_fmul, rand_float(200, 55), rand_float(200, 55));
            end else begin
                issue(op_fmul, rand_float(1, 60), rand_float(1, 60));
            end
        end
        end_test("fmul_saturate");

        start_test();
        for (int i = 0; i < N_OPS; i++) begin
            issue(fpu_op_e'(4'(1 + i % 3)), rand_float(0, 256), rand_float(0, 256));
        end
        end_test("sign_inject");

        start_test();
        for (int i = 0; i < N_OPS; i++) begin
            a = rand_float(0, 256);
            b = rand_float(0, 256);
            // equal operands, then +0 against -0
            if (i % 3 == 1) begin
                b = a;
            end else if (i % 3 == 2) begin
                a.exp = 8'd0;
                b     = '{sign: !a.sign, exp: 8'd0, man: b.man};
            end
            issue(fpu_op_e'(4'(4 + next_rand() % 5)), a, b);
        end
        end_test("min_max_compare");

        start_test();
        for (int i = 0; i < N_OPS; i++) begin
            issue(fpu_op_e'(4'(next_rand() % 9)), rand_float(60, 140), rand_float(60, 140));
            idle(int'(next_rand() % 3));
        end
        end_test("mixed_gaps");

        $display("done: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fpu_mul.f */
+incdir+include
src/fpu_pkg.sv
src/delay_pipe.sv
src/fmul.sv
src/fpu_simple.sv
src/fpu_top.sv
testbench/fpu_chk.sv
testbench/tb_fpu.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fpu -f fpu_mul.f \
    --Mdir obj_dir -o tb_fpu_sim

./obj_dir/tb_fpu_sim > sim.log 2>&1 || {
    cat sim.log
    echo "simulator exited with an error"
    exit 1
}
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
